/* source/surf4_pkg.sv */
package surf4_pkg;

	// Bus widths of the control WISHBONE bus.
	typedef logic [31:0] wb_dat_t;
	typedef logic [19:0] wb_adr_t;
	typedef logic [3:0] wb_sel_t;

	// Word offset of a register inside one slave region.
	typedef logic [2:0] reg_ofs_t;

	// Event counters are a full data word wide.
	typedef logic [31:0] cnt_t;

	// Master request, 59 bits.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_sel_t sel;
		wb_dat_t dat;
	} wb_req_t;

	// Slave response, 34 bits.
	typedef struct packed {
		logic ack;
		logic err;
		wb_dat_t dat;
	} wb_rsp_t;

	// One completed host transaction, 55 bits.
	typedef struct packed {
		logic valid;
		logic we;
		logic err;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_tap_t;

	// Slave regions, chosen by address bits 17..16.
	typedef enum logic [1:0] {
		SLV_ID_CTRL = 2'd0,
		SLV_HK = 2'd1,
		SLV_CAPTURE = 2'd2,
		SLV_NONE = 2'd3
	} slv_sel_t;

	// ASCII "SRF4".
	localparam wb_dat_t DEVICE_ID = 32'h5352_4634;
	localparam wb_dat_t FIRMWARE_VER = 32'h0001_0200;

	// ID/control register map.
	localparam reg_ofs_t REG_ID = 3'd0;
	localparam reg_ofs_t REG_VER = 3'd1;
	localparam reg_ofs_t REG_CTRL = 3'd2;
	localparam reg_ofs_t REG_TRIG_CNT = 3'd3;
	localparam reg_ofs_t REG_PPS_CNT = 3'd4;

	// Housekeeping register map.
	localparam reg_ofs_t HK_REG_SAMPLES = 3'd0;
	localparam reg_ofs_t HK_REG_LAST_TRIG = 3'd1;
	localparam reg_ofs_t HK_REG_ENABLE = 3'd2;

	// Capture register map.
	localparam reg_ofs_t CAP_REG_DATA = 3'd0;
	localparam reg_ofs_t CAP_REG_STATUS = 3'd1;

	// Full byte address of the trigger counter.
	localparam wb_adr_t HK_TRIG_ADR = {2'b00, SLV_ID_CTRL, 11'd0, REG_TRIG_CNT, 2'b00};

	// Control register bit layout.
	localparam int CTRL_LED_BITS = 4;
	localparam int CTRL_ICE_RST_BIT = 8;
	localparam int CTRL_OSC_EN_BIT = 9;

	// Input synchronizer depth.
	localparam int SYNC_STAGES = 2;

endpackage

/* source/wbc_intercon.sv */
`timescale 1ns/100ps

module wbc_intercon (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_req_t host_req_i,
	output surf4_pkg::wb_rsp_t host_rsp_o,
	input surf4_pkg::wb_req_t hk_req_i,
	output surf4_pkg::wb_rsp_t hk_rsp_o,
	output surf4_pkg::wb_req_t id_req_o,
	output surf4_pkg::wb_req_t hk_req_o,
	output surf4_pkg::wb_req_t cap_req_o,
	input surf4_pkg::wb_rsp_t id_rsp_i,
	input surf4_pkg::wb_rsp_t hk_rsp_i,
	input surf4_pkg::wb_rsp_t cap_rsp_i,
	output surf4_pkg::wb_tap_t host_tap_o
);
	import surf4_pkg::*;

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_HOST,
		GNT_HK
	} gnt_state_t;

	gnt_state_t gnt_q;
	gnt_state_t gnt_d;
	wb_req_t gnt_req;
	wb_rsp_t mst_rsp;
	slv_sel_t slv_sel;
	logic err_q;

	// Passes the request on, with cyc and stb only for the selected slave.
	function automatic wb_req_t route(input wb_req_t req, input logic hit);
		wb_req_t r;
		r = req;
		r.cyc = req.cyc & hit;
		r.stb = req.stb & hit;
		return r;
	endfunction

	// Grant stays with a master for as long as it keeps cyc up.
	// The host wins a tie from idle.
	always_comb begin
		gnt_d = gnt_q;
		case (gnt_q)
			GNT_HOST: begin
				if (!host_req_i.cyc)
					gnt_d = hk_req_i.cyc ? GNT_HK : GNT_IDLE;
			end
			GNT_HK: begin
				if (!hk_req_i.cyc)
					gnt_d = host_req_i.cyc ? GNT_HOST : GNT_IDLE;
			end
			default: begin
				if (host_req_i.cyc)
					gnt_d = GNT_HOST;
				else if (hk_req_i.cyc)
					gnt_d = GNT_HK;
			end
		endcase
	end

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			gnt_q <= GNT_IDLE;
		else
			gnt_q <= gnt_d;
	end

	// Request of the master holding the grant.
	always_comb begin
		case (gnt_q)
			GNT_HOST: gnt_req = host_req_i;
			GNT_HK: gnt_req = hk_req_i;
			default: gnt_req = '0;
		endcase
	end

	// Region decode on address bits 17..16.
	assign slv_sel = slv_sel_t'(gnt_req.adr[17:16]);

	assign id_req_o = route(gnt_req, slv_sel == SLV_ID_CTRL);
	assign hk_req_o = route(gnt_req, slv_sel == SLV_HK);
	assign cap_req_o = route(gnt_req, slv_sel == SLV_CAPTURE);

	// Unmapped region answers err one cycle after stb, like a slave would.
	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= gnt_req.cyc & gnt_req.stb & (slv_sel == SLV_NONE) & ~err_q;
	end

	// Response of the selected slave.
	always_comb begin
		case (slv_sel)
			SLV_ID_CTRL: mst_rsp = id_rsp_i;
			SLV_HK: mst_rsp = hk_rsp_i;
			SLV_CAPTURE: mst_rsp = cap_rsp_i;
			default: mst_rsp = '{ack: 1'b0, err: err_q, dat: '0};
		endcase
	end

	// Only the granted master sees a response.
	assign host_rsp_o = (gnt_q == GNT_HOST) ? mst_rsp : '0;
	assign hk_rsp_o = (gnt_q == GNT_HK) ? mst_rsp : '0;

	// Host tap, skipping accesses to the capture block itself.
	assign host_tap_o.valid = (gnt_q == GNT_HOST) & (mst_rsp.ack | mst_rsp.err) &
		(slv_sel != SLV_CAPTURE);
	assign host_tap_o.we = gnt_req.we;
	assign host_tap_o.err = mst_rsp.err;
	assign host_tap_o.adr = gnt_req.adr;
	// Write data on writes, returned data on reads.
	assign host_tap_o.dat = gnt_req.we ? gnt_req.dat : mst_rsp.dat;

endmodule

/* source/surf4_id_ctrl.sv */
`timescale 1ns/100ps

module surf4_id_ctrl (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_req_t wb_req_i,
	output surf4_pkg::wb_rsp_t wb_rsp_o,
	input logic ext_trig_i,
	input logic pps_i,
	output logic pps_tick_o,
	output logic [surf4_pkg::CTRL_LED_BITS-1:0] led_o,
	output logic ice40_reset_o,
	output logic local_osc_en_o
);
	import surf4_pkg::*;

	// Bit 0 carries the trigger, bit 1 the PPS.
	logic [SYNC_STAGES-1:0][1:0] sync_q;
	logic [1:0] prev_q;
	logic [1:0] rise;
	logic pps_tick_q;
	cnt_t trig_cnt_q;
	cnt_t pps_cnt_q;
	logic [CTRL_LED_BITS-1:0] led_q;
	logic ice_rst_q;
	logic osc_en_q;
	logic ack_q;
	wb_dat_t rdat_q;
	wb_dat_t rdat;
	wb_dat_t ctrl_word;
	logic acc;
	logic wr;
	reg_ofs_t ofs;

	// One access per stb, the ack cycle itself is not a new access.
	assign acc = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign wr = acc & wb_req_i.we;
	assign ofs = wb_req_i.adr[4:2];

	// Rising edges after the synchronizer.
	assign rise = sync_q[SYNC_STAGES-1] & ~prev_q;

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q <= '0;
			prev_q <= '0;
			pps_tick_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], {pps_i, ext_trig_i}};
			prev_q <= sync_q[SYNC_STAGES-1];
			pps_tick_q <= rise[1];
		end
	end

	// A write clears the counter and wins over an edge in the same cycle.
	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			trig_cnt_q <= '0;
			pps_cnt_q <= '0;
		end else begin
			if (wr && ofs == REG_TRIG_CNT)
				trig_cnt_q <= '0;
			else if (rise[0])
				trig_cnt_q <= trig_cnt_q + 1'b1;
			if (wr && ofs == REG_PPS_CNT)
				pps_cnt_q <= '0;
			else if (rise[1])
				pps_cnt_q <= pps_cnt_q + 1'b1;
		end
	end

	// Control bits, LEDs in byte 0, ICE40 reset and oscillator in byte 1.
	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_q <= '0;
			ice_rst_q <= 1'b0;
			osc_en_q <= 1'b0;
		end else if (wr && ofs == REG_CTRL) begin
			if (wb_req_i.sel[0])
				led_q <= wb_req_i.dat[CTRL_LED_BITS-1:0];
			if (wb_req_i.sel[1]) begin
				ice_rst_q <= wb_req_i.dat[CTRL_ICE_RST_BIT];
				osc_en_q <= wb_req_i.dat[CTRL_OSC_EN_BIT];
			end
		end
	end

	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_LED_BITS-1:0] = led_q;
		ctrl_word[CTRL_ICE_RST_BIT] = ice_rst_q;
		ctrl_word[CTRL_OSC_EN_BIT] = osc_en_q;
	end

	// Read mux. Unused offsets read zero.
	always_comb begin
		case (ofs)
			REG_ID: rdat = DEVICE_ID;
			REG_VER: rdat = FIRMWARE_VER;
			REG_CTRL: rdat = ctrl_word;
			REG_TRIG_CNT: rdat = trig_cnt_q;
			REG_PPS_CNT: rdat = pps_cnt_q;
			default: rdat = '0;
		endcase
	end

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= acc;
	end

	always_ff @(posedge wbc_clk) begin
		if (acc)
			rdat_q <= rdat;
	end

	assign wb_rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};
	assign pps_tick_o = pps_tick_q;
	assign led_o = led_q;
	assign ice40_reset_o = ice_rst_q;
	assign local_osc_en_o = osc_en_q;

endmodule

/* source/surf4_hk_collector.sv */
`timescale 1ns/100ps

module surf4_hk_collector (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_req_t wbs_req_i,
	output surf4_pkg::wb_rsp_t wbs_rsp_o,
	output surf4_pkg::wb_req_t wbm_req_o,
	input surf4_pkg::wb_rsp_t wbm_rsp_i,
	input logic pps_tick_i
);
	import surf4_pkg::*;

	typedef enum logic {
		HK_IDLE,
		HK_READ
	} hk_state_t;

	hk_state_t state_q;
	logic enable_q;
	cnt_t samples_q;
	wb_dat_t last_trig_q;
	logic ack_q;
	wb_dat_t rdat_q;
	wb_dat_t rdat;
	logic acc;
	reg_ofs_t ofs;

	// Master FSM, one read of the trigger counter per PPS tick.
	// A tick during a pending read is dropped.
	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= HK_IDLE;
			samples_q <= '0;
		end else begin
			case (state_q)
				HK_IDLE: begin
					if (pps_tick_i && enable_q)
						state_q <= HK_READ;
				end
				default: begin
					// Error ends the cycle without a sample.
					if (wbm_rsp_i.ack || wbm_rsp_i.err)
						state_q <= HK_IDLE;
					if (wbm_rsp_i.ack)
						samples_q <= samples_q + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge wbc_clk) begin
		if (state_q == HK_READ && wbm_rsp_i.ack)
			last_trig_q <= wbm_rsp_i.dat;
	end

	// Single-word read request, held until the response.
	assign wbm_req_o.cyc = (state_q == HK_READ);
	assign wbm_req_o.stb = (state_q == HK_READ);
	assign wbm_req_o.we = 1'b0;
	assign wbm_req_o.adr = HK_TRIG_ADR;
	assign wbm_req_o.sel = '1;
	assign wbm_req_o.dat = '0;

	// Slave side.
	assign acc = wbs_req_i.cyc & wbs_req_i.stb & ~ack_q;
	assign ofs = wbs_req_i.adr[4:2];

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			enable_q <= 1'b0;
		else if (acc && wbs_req_i.we && ofs == HK_REG_ENABLE && wbs_req_i.sel[0])
			enable_q <= wbs_req_i.dat[0];
	end

	always_comb begin
		case (ofs)
			HK_REG_SAMPLES: rdat = samples_q;
			HK_REG_LAST_TRIG: rdat = last_trig_q;
			HK_REG_ENABLE: rdat = {31'd0, enable_q};
			default: rdat = '0;
		endcase
	end

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= acc;
	end

	always_ff @(posedge wbc_clk) begin
		if (acc)
			rdat_q <= rdat;
	end

	assign wbs_rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

/* source/wbc_bus_capture.sv */
`timescale 1ns/100ps

module wbc_bus_capture (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_tap_t tap_i,
	input surf4_pkg::wb_req_t wb_req_i,
	output surf4_pkg::wb_rsp_t wb_rsp_o
);
	import surf4_pkg::*;

	wb_dat_t cap_dat_q;
	wb_adr_t cap_adr_q;
	logic cap_we_q;
	logic cap_err_q;
	logic ack_q;
	wb_dat_t rdat_q;
	wb_dat_t rdat;
	logic acc;

	// Snapshot of the last completed host transaction.
	always_ff @(posedge wbc_clk) begin
		if (tap_i.valid) begin
			cap_dat_q <= tap_i.dat;
			cap_adr_q <= tap_i.adr;
		end
	end

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cap_we_q <= 1'b0;
			cap_err_q <= 1'b0;
		end else if (tap_i.valid) begin
			cap_we_q <= tap_i.we;
			cap_err_q <= tap_i.err;
		end
	end

	// Read only, writes get an ack and nothing else.
	assign acc = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// Status word is err, we, then the 20-bit address.
	always_comb begin
		case (reg_ofs_t'(wb_req_i.adr[4:2]))
			CAP_REG_DATA: rdat = cap_dat_q;
			CAP_REG_STATUS: rdat = {10'd0, cap_err_q, cap_we_q, cap_adr_q};
			default: rdat = '0;
		endcase
	end

	always_ff @(posedge wbc_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= acc;
	end

	always_ff @(posedge wbc_clk) begin
		if (acc)
			rdat_q <= rdat;
	end

	assign wb_rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

/* source/surf4_top.sv */
`timescale 1ns/100ps

module surf4_top (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_req_t host_req_i,
	output surf4_pkg::wb_rsp_t host_rsp_o,
	input logic ext_trig_i,
	input logic pps_i,
	output logic [surf4_pkg::CTRL_LED_BITS-1:0] led_o,
	output logic ice40_reset_o,
	output logic local_osc_en_o
);
	import surf4_pkg::*;

	// Housekeeping master port.
	wb_req_t hk_mreq;
	wb_rsp_t hk_mrsp;

	// Slave ports, one per region.
	wb_req_t id_req;
	wb_rsp_t id_rsp;
	wb_req_t hk_sreq;
	wb_rsp_t hk_srsp;
	wb_req_t cap_req;
	wb_rsp_t cap_rsp;

	// Completed host transactions.
	wb_tap_t host_tap;

	// One pulse per synchronized PPS edge.
	logic pps_tick;

	// Shared control bus, two masters and three slaves.
	wbc_intercon u_wbc_intercon (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.host_req_i(host_req_i),
		.host_rsp_o(host_rsp_o),
		.hk_req_i(hk_mreq),
		.hk_rsp_o(hk_mrsp),
		.id_req_o(id_req),
		.hk_req_o(hk_sreq),
		.cap_req_o(cap_req),
		.id_rsp_i(id_rsp),
		.hk_rsp_i(hk_srsp),
		.cap_rsp_i(cap_rsp),
		.host_tap_o(host_tap)
	);

	// ID, board control and trigger/PPS counting.
	surf4_id_ctrl u_surf4_id_ctrl (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.wb_req_i(id_req),
		.wb_rsp_o(id_rsp),
		.ext_trig_i(ext_trig_i),
		.pps_i(pps_i),
		.pps_tick_o(pps_tick),
		.led_o(led_o),
		.ice40_reset_o(ice40_reset_o),
		.local_osc_en_o(local_osc_en_o)
	);

	// Samples the trigger count once per second.
	surf4_hk_collector u_hk_collector (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.wbs_req_i(hk_sreq),
		.wbs_rsp_o(hk_srsp),
		.wbm_req_o(hk_mreq),
		.wbm_rsp_i(hk_mrsp),
		.pps_tick_i(pps_tick)
	);

	// Snapshot of the last host transaction.
	wbc_bus_capture u_bus_capture (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.tap_i(host_tap),
		.wb_req_i(cap_req),
		.wb_rsp_o(cap_rsp)
	);

endmodule

/* test/surf4_asserts.sv */
`timescale 1ns/100ps

module surf4_asserts (
	input logic wbc_clk,
	input logic rst_n_i,
	input surf4_pkg::wb_req_t host_req_i,
	input surf4_pkg::wb_rsp_t host_rsp_i,
	input surf4_pkg::wb_req_t hk_req_i,
	input surf4_pkg::wb_rsp_t hk_rsp_i,
	input surf4_pkg::wb_tap_t tap_i,
	input logic [surf4_pkg::CTRL_LED_BITS-1:0] led_i,
	input logic ice40_reset_i,
	input logic local_osc_en_i
);

	// Failures seen so far, read by the testbench at the end of each test.
	int fail_cnt = 0;

	logic ctrl_outs_zero;

	// All board control outputs low.
	assign ctrl_outs_zero = (led_i == '0) && !ice40_reset_i && !local_osc_en_i;

	// Ack and err never together on either master port.
	host_ack_err_excl: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		!(host_rsp_i.ack && host_rsp_i.err))
		else begin
			$error("host port shows ack and err in the same cycle");
			fail_cnt = fail_cnt + 1;
		end

	hk_ack_err_excl: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		!(hk_rsp_i.ack && hk_rsp_i.err))
		else begin
			$error("housekeeping port shows ack and err in the same cycle");
			fail_cnt = fail_cnt + 1;
		end

	// A single-cycle ack or err on the host port.
	host_rsp_pulse: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		(host_rsp_i.ack || host_rsp_i.err) |=> !(host_rsp_i.ack || host_rsp_i.err))
		else begin
			$error("host response held for more than one cycle");
			fail_cnt = fail_cnt + 1;
		end

	// Responses only reach a master whose stb is up.
	host_rsp_with_stb: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		(host_rsp_i.ack || host_rsp_i.err) |-> host_req_i.stb)
		else begin
			$error("host response without host stb");
			fail_cnt = fail_cnt + 1;
		end

	hk_rsp_with_stb: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		(hk_rsp_i.ack || hk_rsp_i.err) |-> hk_req_i.stb)
		else begin
			$error("housekeeping response without housekeeping stb");
			fail_cnt = fail_cnt + 1;
		end

	// Control outputs stay low in reset and in the first cycle out of it.
	ctrl_low_in_reset: assert property (@(posedge wbc_clk)
		!rst_n_i |-> ctrl_outs_zero)
		else begin
			$error("control outputs not low during reset");
			fail_cnt = fail_cnt + 1;
		end

	ctrl_low_after_reset: assert property (@(posedge wbc_clk)
		$rose(rst_n_i) |-> ctrl_outs_zero)
		else begin
			$error("control outputs not low in the cycle after reset");
			fail_cnt = fail_cnt + 1;
		end

	// A tap entry marks a host response.
	tap_on_host_rsp: assert property (@(posedge wbc_clk) disable iff (!rst_n_i)
		tap_i.valid |-> (host_rsp_i.ack || host_rsp_i.err))
		else begin
			$error("tap valid without a host response");
			fail_cnt = fail_cnt + 1;
		end

endmodule

/* test/surf4_tb.sv */
`timescale 1ns/100ps

module surf4_tb;
	import surf4_pkg::*;

	// Longest run is some 600 cycles, so this is a generous bound.
	localparam int MAX_CYCLES = 4000;

	// ID word, ASCII SRF4.
	localparam logic [31:0] EXP_ID = "SRF4";

	// Writable control bits: LEDs 3..0, ICE40 reset 8, oscillator 9.
	localparam logic [31:0] CTRL_MASK = 32'h0000_030f;

	// Response kinds as {ack, err}.
	localparam logic [1:0] KIND_ACK = 2'b10;
	localparam logic [1:0] KIND_ERR = 2'b01;

	logic wbc_clk;
	logic rst_n_i;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	logic ext_trig;
	logic pps;
	logic [3:0] led;
	logic ice40_reset;
	logic osc_en;

	logic [31:0] lcg_state = 32'd40771;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int test_cnt = 0;
	int test_fail_cnt = 0;
	int err_at_start = 0;
	string test_name;
	logic pps_done;

	surf4_top dut (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.host_req_i(host_req),
		.host_rsp_o(host_rsp),
		.ext_trig_i(ext_trig),
		.pps_i(pps),
		.led_o(led),
		.ice40_reset_o(ice40_reset),
		.local_osc_en_o(osc_en)
	);

	// Protocol checks inside the top level.
	bind surf4_top surf4_asserts u_asserts (
		.wbc_clk(wbc_clk),
		.rst_n_i(rst_n_i),
		.host_req_i(host_req_i),
		.host_rsp_i(host_rsp_o),
		.hk_req_i(hk_mreq),
		.hk_rsp_i(hk_mrsp),
		.tap_i(host_tap),
		.led_i(led_o),
		.ice40_reset_i(ice40_reset_o),
		.local_osc_en_i(local_osc_en_o)
	);

	initial begin
		wbc_clk = 1'b0;
		forever #20 wbc_clk = ~wbc_clk;
	end

	// Run limit.
	always @(posedge wbc_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// LCG, the upper bits are the useful ones.
	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_rand();
		return lo + int'(r[23:8] % 16'(hi - lo + 1));
	endfunction

	// Byte address from region and register offset.
	function automatic wb_adr_t make_adr(input logic [1:0] region, input logic [2:0] ofs);
		return {2'b00, region, 11'd0, ofs, 2'b00};
	endfunction

	function int total_errors();
		return err_cnt + dut.u_asserts.fail_cnt;
	endfunction

	// Inputs change 2 ns after the rising edge.
	task automatic next_cycle();
		@(posedge wbc_clk);
		#2;
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
			err_cnt++;
		end
	endtask

	// One classic transfer, held through the ack or err cycle, then one idle cycle.
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
		output wb_dat_t rdat, output logic [1:0] kind);
		host_req.cyc = 1'b1;
		host_req.stb = 1'b1;
		host_req.we = we;
		host_req.adr = adr;
		host_req.sel = 4'hf;
		host_req.dat = wdat;
		// Response sampled 1 ns after the edge.
		do begin
			@(posedge wbc_clk);
			#1;
		end while (!(host_rsp.ack || host_rsp.err));
		rdat = host_rsp.dat;
		kind = {host_rsp.ack, host_rsp.err};
		// Request stays up until the edge that closes the response cycle.
		next_cycle();
		host_req = '0;
		next_cycle();
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_dat_t wdat);
		wb_dat_t rdat;
		logic [1:0] kind;
		bus_access(1'b1, adr, wdat, rdat, kind);
		check_word("host_rsp kind", {30'd0, KIND_ACK}, {30'd0, kind});
	endtask

	task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat);
		logic [1:0] kind;
		bus_access(1'b0, adr, '0, rdat, kind);
		check_word("host_rsp kind", {30'd0, KIND_ACK}, {30'd0, kind});
	endtask

	task automatic pulse_trig(input int high, input int low);
		ext_trig = 1'b1;
		repeat (high) next_cycle();
		ext_trig = 1'b0;
		repeat (low) next_cycle();
	endtask

	task automatic pulse_pps(input int high, input int low);
		pps = 1'b1;
		repeat (high) next_cycle();
		pps = 1'b0;
		repeat (low) next_cycle();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = total_errors();
	endtask

	task automatic finish_test();
		int errs;
		errs = total_errors() - err_at_start;
		test_cnt++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", test_cnt, test_name);
		end else begin
			test_fail_cnt++;
			$display("Test %0d %s: %0d errors", test_cnt, test_name, errs);
		end
	endtask

	initial begin
		wb_dat_t rdat;
		wb_dat_t v;
		wb_adr_t bad_adr;
		logic [1:0] kind;
		int n;
		int m;
		int t;
		int k;
		rst_n_i = 1'b0;
		host_req = '0;
		ext_trig = 1'b0;
		pps = 1'b0;
		pps_done = 1'b0;
		repeat (3) @(posedge wbc_clk);
		#2;
		rst_n_i = 1'b1;
		next_cycle();

		// ID and version are constant, writes to them do nothing.
		start_test("id registers");
		bus_read(make_adr(SLV_ID_CTRL, REG_ID), rdat);
		check_word("REG_ID", EXP_ID, rdat);
		bus_read(make_adr(SLV_ID_CTRL, REG_VER), rdat);
		check_word("REG_VER", FIRMWARE_VER, rdat);
		bus_write(make_adr(SLV_ID_CTRL, REG_ID), next_rand());
		bus_read(make_adr(SLV_ID_CTRL, REG_ID), rdat);
		check_word("REG_ID", EXP_ID, rdat);
		finish_test();

		// Control register read back and its output pins.
		start_test("control");
		v = next_rand();
		bus_write(make_adr(SLV_ID_CTRL, REG_CTRL), v);
		check_word("led_o", {28'd0, v[3:0]}, {28'd0, led});
		check_word("ice40_reset_o", {31'd0, v[8]}, {31'd0, ice40_reset});
		check_word("local_osc_en_o", {31'd0, v[9]}, {31'd0, osc_en});
		bus_read(make_adr(SLV_ID_CTRL, REG_CTRL), rdat);
		check_word("REG_CTRL", v & CTRL_MASK, rdat);
		finish_test();

		// Edge counting with the collector still disabled.
		start_test("trigger and pps counting");
		bus_write(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), '0);
		bus_write(make_adr(SLV_ID_CTRL, REG_PPS_CNT), '0);
		n = rand_range(3, 8);
		m = rand_range(1, 4);
		for (int i = 0; i < n; i++)
			pulse_trig(rand_range(4, 7), rand_range(4, 7));
		for (int i = 0; i < m; i++)
			pulse_pps(rand_range(4, 7), rand_range(4, 7));
		bus_read(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), rdat);
		check_word("REG_TRIG_CNT", 32'(n), rdat);
		bus_read(make_adr(SLV_ID_CTRL, REG_PPS_CNT), rdat);
		check_word("REG_PPS_CNT", 32'(m), rdat);
		bus_write(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), next_rand());
		bus_read(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), rdat);
		check_word("REG_TRIG_CNT", 32'd0, rdat);
		finish_test();

		// Region 3 answers err, for reads and writes.
		start_test("unmapped address");
		bus_access(1'b0, make_adr(2'd3, 3'd0), '0, rdat, kind);
		check_word("host_rsp kind", {30'd0, KIND_ERR}, {30'd0, kind});
		bus_access(1'b1, make_adr(2'd3, 3'd2), next_rand(), rdat, kind);
		check_word("host_rsp kind", {30'd0, KIND_ERR}, {30'd0, kind});
		finish_test();

		// Snapshot of the last host transaction outside the capture block.
		start_test("bus capture");
		v = next_rand();
		bus_write(make_adr(SLV_ID_CTRL, REG_CTRL), v);
		bus_read(make_adr(SLV_CAPTURE, CAP_REG_DATA), rdat);
		check_word("capture data", v, rdat);
		bus_read(make_adr(SLV_CAPTURE, CAP_REG_STATUS), rdat);
		check_word("capture status", {10'd0, 1'b0, 1'b1, make_adr(SLV_ID_CTRL, REG_CTRL)}, rdat);
		bad_adr = make_adr(2'd3, 3'd5);
		bus_access(1'b0, bad_adr, '0, rdat, kind);
		check_word("host_rsp kind", {30'd0, KIND_ERR}, {30'd0, kind});
		bus_read(make_adr(SLV_CAPTURE, CAP_REG_STATUS), rdat);
		check_word("capture status", {10'd0, 1'b1, 1'b0, bad_adr}, rdat);
		finish_test();

		// Collector samples once per PPS while the host keeps the bus busy.
		start_test("housekeeping");
		bus_write(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), '0);
		bus_write(make_adr(SLV_HK, HK_REG_ENABLE), 32'd1);
		t = rand_range(2, 8);
		k = rand_range(2, 4);
		for (int i = 0; i < t; i++)
			pulse_trig(rand_range(4, 7), rand_range(4, 7));
		fork
			begin
				for (int i = 0; i < k; i++)
					pulse_pps(4, rand_range(20, 30));
				pps_done = 1'b1;
			end
			begin
				while (!pps_done) begin
					bus_read(make_adr(SLV_ID_CTRL, REG_TRIG_CNT), rdat);
					check_word("REG_TRIG_CNT", 32'(t), rdat);
				end
			end
		join
		bus_read(make_adr(SLV_HK, HK_REG_SAMPLES), rdat);
		check_word("hk sample count", 32'(k), rdat);
		bus_read(make_adr(SLV_HK, HK_REG_LAST_TRIG), rdat);
		check_word("hk last trigger count", 32'(t), rdat);
		finish_test();

		$display("Tests run %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt,
			total_errors());
		if (total_errors() == 0 && test_fail_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
source/surf4_pkg.sv
source/wbc_intercon.sv
source/surf4_id_ctrl.sv
source/surf4_hk_collector.sv
source/wbc_bus_capture.sv
source/surf4_top.sv
test/surf4_asserts.sv
test/surf4_tb.sv

/* Makefile */
# Verilator build and run of the SURF4 control bus testbench.

SRCS := $(wildcard source/*.sv test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
obj_dir/Vsurf4_tb: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module surf4_tb -f sources.f -o Vsurf4_tb

# The log decides pass or fail.
run: obj_dir/Vsurf4_tb
	obj_dir/Vsurf4_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
